/* bench/clockGen.sv */
/* free-running clock with period 20; reset is held low for the first two
   rising edges and released just after the second one */
`default_nettype none

module clockGen (
    output logic clk,
    output logic arstN
);

    localparam int HalfPeriod = 10;

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (2) @(posedge clk);
        #1 arstN = 1'b1;
    end

endmodule

`default_nettype wire

/* bench/ramModel.sv */
/* 128 KB byte RAM, only addr[16:0] is decoded; read data follows the address
   by one clock and the model itself ignores rdyIn */
`default_nettype none

module ramModel (
    input  wire logic        clk,
    input  wire logic [31:0] addr,
    input  wire logic [7:0]  wdata,
    input  wire logic        wr,
    output logic      [7:0]  rdata
);

    localparam int Bytes = 131072;

    // preloaded from the testbench before reset is released
    logic [7:0] mem [0:Bytes-1];

    always @(posedge clk) begin
        if (wr)
            mem[addr[16:0]] <= wdata;
        // old data on a write to the same byte
        rdata <= mem[addr[16:0]];
    end

endmodule

`default_nettype wire

/* bench/tbMemSubsystem.sv */
/* directed tests for the shared RAM bus; expected data comes from a shadow
   copy of the RAM, test addresses stay in 0x100..0x100ff */
`default_nettype none

module tbMemSubsystem import memPkg::*; ();

    localparam int NumTests  = 6;
    localparam int ClkPeriod = 20;
    localparam int RamBytes  = 131072;

    logic                 clk;
    logic                 arstN;
    logic                 rdyIn;
    logic                 misTaken;
    logic                 fetchEn;
    logic [AddrWidth-1:0] fetchAddr;
    logic                 instOutEn;
    logic [WordWidth-1:0] inst;
    logic                 lsEn;
    logic                 lsWrite;
    accessLen_e           lsLen;
    logic [AddrWidth-1:0] lsAddr;
    logic [WordWidth-1:0] sData;
    logic                 lsDone;
    logic [WordWidth-1:0] ldData;
    logic [7:0]           memDin;
    logic [7:0]           memDout;
    logic [31:0]          memA;
    logic                 memWr;
    logic [7:0]           shadow [0:RamBytes-1];
    logic [31:0]          storeBase;
    logic [31:0]          storeData;
    int                   seed = 32'hd13e;

    clockGen clocks (.clk(clk), .arstN(arstN));

    ramModel ram (
        .clk   (clk),
        .addr  (memA),
        .wdata (memDout),
        .wr    (memWr),
        .rdata (memDin)
    );

    memSubsystem dut_i (
        .clk_in    (clk),
        .arstN     (arstN),
        .rdyIn     (rdyIn),
        .misTaken  (misTaken),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .instOutEn (instOutEn),
        .inst      (inst),
        .lsEn      (lsEn),
        .lsWrite   (lsWrite),
        .lsLen     (lsLen),
        .lsAddr    (lsAddr),
        .sData     (sData),
        .lsDone    (lsDone),
        .ldData    (ldData),
        .memDin    (memDin),
        .memDout   (memDout),
        .memA      (memA),
        .memWr     (memWr)
    );

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else stopRun($sformatf("Fail %s: got %h, expected %h", name, got, exp));
    endtask

    // every byte of the 17-bit address feeds the fill value
    function automatic logic [7:0] fillByte(input int i);
        return 8'(i ^ (i >> 8) ^ (i >> 16));
    endfunction

    function automatic int randAddr();
        return 256 + ($random(seed) & 32'hffff);
    endfunction

    // little-endian, bytes above n stay zero
    function automatic logic [31:0] expBytes(input int a, input int n);
        logic [31:0] w;
        w = '0;
        for (int b = 0; b < n; b++)
            w[8*b +: 8] = shadow[a + b];
        return w;
    endfunction

    // a store puts byte k of its data at its start address plus k
    function automatic logic [7:0] storeByte(input logic [31:0] addr);
        logic [31:0] k;
        k = addr - storeBase;
        if (k > 3)
            return 8'hxx;
        return storeData[8*k +: 8];
    endfunction

    // one clock, paused at random when allowed
    task automatic step(input bit mayPause);
        logic [31:0] heldA;
        bit          paused;
        paused = mayPause && ($random(seed) % 3 == 0);
        rdyIn  = !paused;
        #2;
        heldA = memA;
        if (paused)
            checkEq("memWr", 32'(memWr), 0);
        else if (memWr)
            checkEq("memDout", 32'(memDout), 32'(storeByte(memA)));
        @(posedge clk);
        #1;
        if (paused)
            checkEq("memA", memA, heldA);
        checkEq("memA[31:18]", 32'(memA[31:18]), 0);
    endtask

    task automatic fetchWord(input int a, input bit mayPause, output int cycles);
        fetchAddr = AddrWidth'(a);
        fetchEn   = 1'b1;
        step(1'b0);
        fetchEn = 1'b0;
        cycles  = 1;
        while (!instOutEn) begin
            step(mayPause);
            cycles++;
        end
        checkEq("inst", inst, expBytes(a, 4));
    endtask

    task automatic lsAccess(input bit wr, input int n, input int a, input logic [31:0] d,
                            input bit mayPause, output int cycles);
        logic [31:0] exp;
        exp       = expBytes(a, n);
        lsWrite   = wr;
        lsLen     = (n == 1) ? lenByte : (n == 2) ? lenHalf : lenWord;
        lsAddr    = AddrWidth'(a);
        sData     = d;
        storeBase = a;
        storeData = d;
        lsEn      = 1'b1;
        step(1'b0);
        lsEn   = 1'b0;
        cycles = 1;
        while (!lsDone) begin
            step(mayPause);
            cycles++;
        end
        if (wr) begin
            for (int b = 0; b < n; b++)
                shadow[a + b] = d[8*b +: 8];
        end else begin
            checkEq("ldData", ldData, exp);
        end
    endtask

    task automatic resetTest();
        checkEq("memWr", 32'(memWr), 0);
        checkEq("instOutEn", 32'(instOutEn), 0);
        checkEq("lsDone", 32'(lsDone), 0);
        checkEq("memA", memA, 0);
    endtask

    task automatic fetchTest();
        int cyc;
        fetchWord(randAddr(), 1'b0, cyc);
        checkEq("instOutEn latency", cyc, 6);
    endtask

    task automatic storeLoadTest();
        int          a;
        int          n;
        int          cyc;
        logic [31:0] d;
        for (int k = 0; k < 3; k++) begin
            n = 1 << k;
            a = randAddr();
            d = $random(seed);
            lsAccess(1'b1, n, a, d, 1'b0, cyc);
            checkEq("store lsDone latency", cyc, n + 1);
            lsAccess(1'b0, n, a, 0, 1'b0, cyc);
            checkEq("load lsDone latency", cyc, n + 2);
            // words straddling both ends of the stored bytes catch stray writes
            lsAccess(1'b0, 4, a - 1, 0, 1'b0, cyc);
            lsAccess(1'b0, 4, a + n - 3, 0, 1'b0, cyc);
        end
    endtask

    task automatic contentionTest();
        int af;
        int al;
        int cyc;
        int instAt;
        int lsAt;
        af        = randAddr();
        al        = randAddr();
        fetchAddr = AddrWidth'(af);
        lsAddr    = AddrWidth'(al);
        lsLen     = lenWord;
        lsWrite   = 1'b0;
        fetchEn   = 1'b1;
        lsEn      = 1'b1;
        step(1'b0);
        fetchEn = 1'b0;
        lsEn    = 1'b0;
        cyc     = 1;
        instAt  = 0;
        lsAt    = 0;
        while (instAt == 0 || lsAt == 0) begin
            if (lsDone && lsAt == 0) begin
                lsAt = cyc;
                checkEq("ldData", ldData, expBytes(al, 4));
            end
            if (instOutEn && instAt == 0) begin
                instAt = cyc;
                checkEq("inst", inst, expBytes(af, 4));
            end
            step(1'b0);
            cyc++;
        end
        assert (lsAt < instAt)
        else stopRun("under contention the load did not finish before the fetch");
    endtask

    task automatic flushTest();
        int cyc;
        fetchAddr = AddrWidth'(randAddr());
        fetchEn   = 1'b1;
        step(1'b0);
        fetchEn = 1'b0;
        step(1'b0);
        // two bytes issued, one still in flight
        misTaken = 1'b1;
        step(1'b0);
        misTaken = 1'b0;
        repeat (8) begin
            checkEq("instOutEn", 32'(instOutEn), 0);
            step(1'b0);
        end
        fetchWord(randAddr(), 1'b0, cyc);
        checkEq("instOutEn latency", cyc, 6);
    endtask

    task automatic pauseTest();
        int          a;
        int          cyc;
        logic [31:0] d;
        fetchWord(randAddr(), 1'b1, cyc);
        a = randAddr();
        d = $random(seed);
        lsAccess(1'b1, 4, a, d, 1'b1, cyc);
        lsAccess(1'b0, 4, a, 0, 1'b0, cyc);
    endtask

    initial begin
        #(NumTests * 200 * ClkPeriod);
        stopRun("timeout, the tests did not finish in time");
    end

    initial begin
        rdyIn     = 1'b1;
        misTaken  = 1'b0;
        fetchEn   = 1'b0;
        fetchAddr = '0;
        lsEn      = 1'b0;
        lsWrite   = 1'b0;
        lsLen     = lenByte;
        lsAddr    = '0;
        sData     = '0;
        for (int i = 0; i < RamBytes; i++) begin
            shadow[i]  = fillByte(i);
            ram.mem[i] = shadow[i];
        end
        wait (arstN === 1'b1);
        @(posedge clk);
        #1;
        resetTest();
        fetchTest();
        storeLoadTest();
        contentionTest();
        flushTest();
        pauseTest();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* design/busArbiter.sv */
/* one owner per transaction, load/store wins a tie; read bytes return
   one enabled cycle after the address, a byte arriving in a pause is kept */
`default_nettype none

module busArbiter import memPkg::*; (
    input  wire logic        clk_in,
    input  wire logic        arstN,
    input  wire logic        rdyIn,
    input  wire logic [7:0]  memDin,
    output logic      [7:0]  memDout,
    output logic      [31:0] memA,
    output logic             memWr,
    memBusIf.arbiter         fetchBus,
    memBusIf.arbiter         lsBus
);

    arbState_e            owner;
    arbState_e            curOwner;
    arbState_e            pendOwner;
    logic                 fetchIssue;
    logic                 lsIssue;
    logic                 readIssued;
    logic                 freshRead;
    logic [7:0]           savedByte;
    logic [7:0]           readByte;
    logic [AddrWidth-1:0] busAddr;

    // keep the owner while its transaction is open, else pick a new one
    always_comb begin
        if (owner == arbFetch && fetchBus.hold)
            curOwner = arbFetch;
        else if (owner == arbLoadStore && lsBus.hold)
            curOwner = arbLoadStore;
        else if (lsBus.req)
            curOwner = arbLoadStore;
        else if (fetchBus.req)
            curOwner = arbFetch;
        else
            curOwner = arbIdle;
    end

    assign fetchBus.grant = (curOwner == arbFetch) && fetchBus.req;
    assign lsBus.grant    = (curOwner == arbLoadStore) && lsBus.req;
    assign fetchIssue     = fetchBus.grant && rdyIn;
    assign lsIssue        = lsBus.grant && rdyIn;
    assign readIssued     = (fetchIssue && !fetchBus.write) || (lsIssue && !lsBus.write);

    always_comb begin
        case (curOwner)
            arbFetch:     busAddr = fetchBus.addr;
            arbLoadStore: busAddr = lsBus.addr;
            default:      busAddr = '0;
        endcase
    end

    assign memA    = {{(32-AddrWidth){1'b0}}, busAddr};
    assign memDout = (curOwner == arbLoadStore) ? lsBus.wdata : fetchBus.wdata;
    assign memWr   = (lsIssue && lsBus.write) || (fetchIssue && fetchBus.write);

    always_ff @(posedge clk_in or negedge arstN) begin
        if (!arstN) begin
            owner     <= arbIdle;
            pendOwner <= arbIdle;
            freshRead <= 1'b0;
        end else begin
            // RAM data is on memDin exactly one clock after the address
            freshRead <= readIssued;
            if (rdyIn) begin
                owner     <= curOwner;
                pendOwner <= readIssued ? curOwner : arbIdle;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (freshRead)
            savedByte <= memDin;
    end

    assign readByte        = freshRead ? memDin : savedByte;
    assign fetchBus.rdata  = readByte;
    assign lsBus.rdata     = readByte;
    assign fetchBus.rvalid = rdyIn && (pendOwner == arbFetch);
    assign lsBus.rvalid    = rdyIn && (pendOwner == arbLoadStore);

    assert property (@(posedge clk_in) disable iff (!arstN)
        !(fetchBus.grant && lsBus.grant));

    // no RAM write may happen during a pause
    assert property (@(posedge clk_in) disable iff (!arstN)
        !rdyIn |-> !memWr);

endmodule

`default_nettype wire

/* design/fetchPort.sv */
/* fetches four bytes little-endian; misTaken drops the fetch in flight
   and any late read byte, and a busy port ignores fetchEn */
`default_nettype none

module fetchPort import memPkg::*; (
    input  wire logic                 clk_in,
    input  wire logic                 arstN,
    input  wire logic                 rdyIn,
    input  wire logic                 misTaken,
    input  wire logic                 fetchEn,
    input  wire logic [AddrWidth-1:0] fetchAddr,
    output logic                      instOutEn,
    output logic [WordWidth-1:0]      inst,
    memBusIf.client                   bus
);

    portState_e           state;
    logic [AddrWidth-1:0] addrQ;
    logic [1:0]           txCnt;
    logic [1:0]           rxCnt;
    logic                 issue;
    logic                 takeByte;

    assign issue    = bus.req && bus.grant && rdyIn;
    // late bytes after a flush land while idle and are dropped
    assign takeByte = bus.rvalid && (state != portIdle) && !misTaken;

    always_ff @(posedge clk_in or negedge arstN) begin
        if (!arstN) begin
            state     <= portIdle;
            txCnt     <= 2'd0;
            rxCnt     <= 2'd0;
            instOutEn <= 1'b0;
        end else if (misTaken) begin
            state     <= portIdle;
            instOutEn <= 1'b0;
        end else if (rdyIn) begin
            instOutEn <= 1'b0;
            case (state)
                portIdle: begin
                    if (fetchEn) begin
                        state <= portIssue;
                        txCnt <= 2'd0;
                        rxCnt <= 2'd0;
                    end
                end
                portIssue: begin
                    if (issue) begin
                        txCnt <= txCnt + 2'd1;
                        if (txCnt == 2'd3)
                            state <= portDrain;
                    end
                end
                portDrain: begin
                    // fourth byte completes the word
                    if (bus.rvalid) begin
                        state     <= portIdle;
                        instOutEn <= 1'b1;
                    end
                end
                default: state <= portIdle;
            endcase
            if (takeByte)
                rxCnt <= rxCnt + 2'd1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdyIn) begin
            if (state == portIdle && fetchEn)
                addrQ <= fetchAddr;
            else if (issue)
                addrQ <= addrQ + AddrWidth'(1);
            // lowest address lands in the low byte
            if (takeByte)
                inst[8*rxCnt +: 8] <= bus.rdata;
        end
    end

    assign bus.req   = (state == portIssue);
    assign bus.write = 1'b0;
    assign bus.addr  = addrQ;
    assign bus.wdata = 8'h00;
    assign bus.hold  = (state != portIdle);

    // the word completes only on its fourth returned byte
    assert property (@(posedge clk_in) disable iff (!arstN)
        (state == portDrain && takeByte) |-> (rxCnt == 2'd3));

endmodule

`default_nettype wire

/* design/loadStorePort.sv */
/* 1, 2 or 4 byte loads and stores, low byte first; loads are zero-extended
   and there is no flush, only committed accesses arrive here */
`default_nettype none

module loadStorePort import memPkg::*; (
    input  wire logic                 clk_in,
    input  wire logic                 arstN,
    input  wire logic                 rdyIn,
    input  wire logic                 lsEn,
    input  wire logic                 lsWrite,
    input  wire accessLen_e           lsLen,
    input  wire logic [AddrWidth-1:0] lsAddr,
    input  wire logic [WordWidth-1:0] sData,
    output logic                      lsDone,
    output logic [WordWidth-1:0]      ldData,
    memBusIf.client                   bus
);

    portState_e           state;
    logic                 writeQ;
    logic [1:0]           lastIdx;
    logic [1:0]           txCnt;
    logic [1:0]           rxCnt;
    logic [AddrWidth-1:0] addrQ;
    logic [WordWidth-1:0] sBuf;
    logic                 issue;

    // index of the final byte for each access size
    function automatic logic [1:0] lastByte(input accessLen_e len);
        case (len)
            lenByte: lastByte = 2'd0;
            lenHalf: lastByte = 2'd1;
            default: lastByte = 2'd3;
        endcase
    endfunction

    assign issue = bus.req && bus.grant && rdyIn;

    always_ff @(posedge clk_in or negedge arstN) begin
        if (!arstN) begin
            state   <= portIdle;
            writeQ  <= 1'b0;
            lastIdx <= 2'd0;
            txCnt   <= 2'd0;
            rxCnt   <= 2'd0;
            lsDone  <= 1'b0;
        end else if (rdyIn) begin
            lsDone <= 1'b0;
            case (state)
                portIdle: begin
                    if (lsEn) begin
                        state   <= portIssue;
                        writeQ  <= lsWrite;
                        lastIdx <= lastByte(lsLen);
                        txCnt   <= 2'd0;
                        rxCnt   <= 2'd0;
                    end
                end
                portIssue: begin
                    if (issue) begin
                        txCnt <= txCnt + 2'd1;
                        if (txCnt == lastIdx) begin
                            // a store is done once its last byte is written
                            if (writeQ) begin
                                state  <= portIdle;
                                lsDone <= 1'b1;
                            end else begin
                                state <= portDrain;
                            end
                        end
                    end
                end
                portDrain: begin
                    if (bus.rvalid) begin
                        state  <= portIdle;
                        lsDone <= 1'b1;
                    end
                end
                default: state <= portIdle;
            endcase
            if (bus.rvalid)
                rxCnt <= rxCnt + 2'd1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdyIn) begin
            if (state == portIdle && lsEn) begin
                addrQ  <= lsAddr;
                sBuf   <= sData;
                ldData <= '0;
            end else if (issue) begin
                addrQ <= addrQ + AddrWidth'(1);
                sBuf  <= sBuf >> 8;
            end
            if (bus.rvalid)
                ldData[8*rxCnt +: 8] <= bus.rdata;
        end
    end

    assign bus.req   = (state == portIssue);
    assign bus.write = writeQ;
    assign bus.addr  = addrQ;
    assign bus.wdata = sBuf[7:0];
    assign bus.hold  = (state != portIdle);

    // the bus stays claimed from every issued byte until lsDone
    assert property (@(posedge clk_in) disable iff (!arstN)
        issue |=> (bus.hold || lsDone));

endmodule

`default_nettype wire

/* design/memBusIf.sv */
/* one client's byte requests toward the arbiter;
   a byte is issued only when req, grant and rdyIn are high together */
`default_nettype none

interface memBusIf import memPkg::*; ();

    // client side
    logic                 req;
    logic                 write;
    logic [AddrWidth-1:0] addr;
    logic [7:0]           wdata;
    logic                 hold;

    // arbiter side
    logic                 grant;
    logic [7:0]           rdata;
    logic                 rvalid;

    modport client (
        output req, write, addr, wdata, hold,
        input  grant, rdata, rvalid
    );

    modport arbiter (
        input  req, write, addr, wdata, hold,
        output grant, rdata, rvalid
    );

endinterface

`default_nettype wire

/* design/memPkg.sv */
/* widths, access sizes and FSM encodings for the memory subsystem;
   only 18 address bits reach the RAM bus */
`default_nettype none

package memPkg;

    // byte address bits driven on the RAM bus, upper bits of memA are zero
    localparam int AddrWidth = 18;

    // instruction and load/store data width
    localparam int WordWidth = 32;

    // load/store size
    typedef enum logic [1:0] {
        lenByte,
        lenHalf,
        lenWord
    } accessLen_e;

    // client port FSM, drain waits for the last read byte
    typedef enum logic [1:0] {
        portIdle,
        portIssue,
        portDrain
    } portState_e;

    // current bus owner
    typedef enum logic [1:0] {
        arbIdle,
        arbFetch,
        arbLoadStore
    } arbState_e;

endpackage

`default_nettype wire

/* design/memSubsystem.sv */
/* shares one byte-wide RAM bus between fetch and load/store;
   freezes while rdyIn is low, memA[31:18] is always zero */
`default_nettype none

module memSubsystem import memPkg::*; (
    input  wire logic                 clk_in,
    input  wire logic                 arstN,
    input  wire logic                 rdyIn,
    input  wire logic                 misTaken,

    input  wire logic                 fetchEn,
    input  wire logic [AddrWidth-1:0] fetchAddr,
    output logic                      instOutEn,
    output logic [WordWidth-1:0]      inst,

    input  wire logic                 lsEn,
    input  wire logic                 lsWrite,
    input  wire accessLen_e           lsLen,
    input  wire logic [AddrWidth-1:0] lsAddr,
    input  wire logic [WordWidth-1:0] sData,
    output logic                      lsDone,
    output logic [WordWidth-1:0]      ldData,

    input  wire logic [7:0]           memDin,
    output logic      [7:0]           memDout,
    output logic      [31:0]          memA,
    output logic                      memWr
);

    memBusIf fetchBus ();
    memBusIf lsBus ();

    fetchPort fetcher (
        .clk_in    (clk_in),
        .arstN     (arstN),
        .rdyIn     (rdyIn),
        .misTaken  (misTaken),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .instOutEn (instOutEn),
        .inst      (inst),
        .bus       (fetchBus.client)
    );

    // load/store port, fed by the non-speculative buffer
    loadStorePort lsPort (
        .clk_in  (clk_in),
        .arstN   (arstN),
        .rdyIn   (rdyIn),
        .lsEn    (lsEn),
        .lsWrite (lsWrite),
        .lsLen   (lsLen),
        .lsAddr  (lsAddr),
        .sData   (sData),
        .lsDone  (lsDone),
        .ldData  (ldData),
        .bus     (lsBus.client)
    );

    busArbiter arbiter (
        .clk_in   (clk_in),
        .arstN    (arstN),
        .rdyIn    (rdyIn),
        .memDin   (memDin),
        .memDout  (memDout),
        .memA     (memA),
        .memWr    (memWr),
        .fetchBus (fetchBus.arbiter),
        .lsBus    (lsBus.arbiter)
    );

endmodule

`default_nettype wire

/* project.f */
design/memPkg.sv
design/memBusIf.sv
design/fetchPort.sv
design/loadStorePort.sv
design/busArbiter.sv
design/memSubsystem.sv
bench/clockGen.sv
bench/ramModel.sv
bench/tbMemSubsystem.sv

/* run.sh */
#!/bin/sh
# Verilator build and run; the result is taken from the simulation log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tbMemSubsystem \
    -f project.f -o simMemSubsystem > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/simMemSubsystem > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulator returned an error status, see sim.log"
fi

if grep -q "STATUS: PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
